/* rtl/nmi_watch_pkg.sv */
// Shared widths, retirement budgets and the error latch state encoding
`default_nettype none

package nmi_watch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Outstanding transaction tracking
  //////////////////////////////////////////////////////////////////////

  // Depth of the in-order type queue, matching the core's LSU limit
  localparam int MAX_OUTSTANDING_DEFAULT = 2;

  //////////////////////////////////////////////////////////////////////
  // Retirement budget
  //////////////////////////////////////////////////////////////////////

  // Retirement count that saturates at three
  typedef logic [1:0] retire_cnt_t;

  // One instruction already retired together with the error response
  localparam retire_cnt_t RETIRE_BUDGET_AT_ERROR = 2'd2;

  // Nothing retired in the error cycle, so one more retirement is allowed
  localparam retire_cnt_t RETIRE_BUDGET_NO_RETIRE = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Error latch
  //////////////////////////////////////////////////////////////////////

  // Idle until the first error response, latched until the handler is taken
  typedef enum logic {
    ERR_IDLE    = 1'b0,
    ERR_LATCHED = 1'b1
  } err_state_e;

endpackage

`default_nettype wire

/* rtl/obi_outstanding_tracker.sv */
// Outstanding bus transaction counter with an in-order queue of transaction types
`timescale 1ns/1ns
`default_nettype none

module obi_outstanding_tracker #(
  parameter int MAX_OUTSTANDING = nmi_watch_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 bus_req_i,
  input  logic                                 bus_gnt_i,
  input  logic                                 bus_we_i,
  input  logic                                 bus_rvalid_i,
  input  logic                                 bus_err_i,
  output logic                                 resp_valid_o,
  output logic                                 resp_err_o,
  output logic                                 resp_is_write_o,
  output logic [$clog2(MAX_OUTSTANDING+1)-1:0] outstanding_cnt_o
);

  // Enough bits to hold the full range zero up to the queue depth
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [CNT_W-1:0]           cnt_t;
  typedef logic [MAX_OUTSTANDING-1:0] type_queue_t;

  cnt_t        cnt_q;
  type_queue_t type_q;
  logic        issue;

  //////////////////////////////////////////////////////////////////////
  // Issue and response detection
  //////////////////////////////////////////////////////////////////////

  // A transaction is issued when the request is granted
  assign issue = bus_req_i && bus_gnt_i;

  // Responses come back in order, so rvalid always belongs to the oldest entry
  assign resp_valid_o = bus_rvalid_i;
  assign resp_err_o   = bus_rvalid_i && bus_err_i;

  //////////////////////////////////////////////////////////////////////
  // Count and type queue
  //////////////////////////////////////////////////////////////////////

  // The newest type enters at index 0 and older entries move up by one
  // The oldest entry therefore sits at index cnt_q-1
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      type_q <= '0;
    end else begin
      if (issue && !bus_rvalid_i) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (!issue && bus_rvalid_i) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
      // A response without an issue only drops the count, the stale slot is ignored
      if (issue) begin
        for (int i = MAX_OUTSTANDING - 1; i > 0; i--) begin
          type_q[i] <= type_q[i-1];
        end
        type_q[0] <= bus_we_i;
      end
    end
  end

  // Select the oldest outstanding type; zero when nothing is outstanding
  always_comb begin
    resp_is_write_o = 1'b0;
    for (int i = 0; i < MAX_OUTSTANDING; i++) begin
      if (cnt_q == cnt_t'(i + 1)) begin
        resp_is_write_o = type_q[i];
      end
    end
  end

  assign outstanding_cnt_o = cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////////////

  // A response can only answer a transaction issued in an earlier cycle
  a_no_resp_when_empty :
    assert property (@(posedge clk) disable iff (!rst_n)
                     bus_rvalid_i |-> (cnt_q != '0))
      else $error("Response received with no outstanding transaction");

  // The queue would overflow if a full tracker saw an issue without a response
  a_no_issue_when_full :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (issue && (cnt_q == cnt_t'(MAX_OUTSTANDING))) |-> bus_rvalid_i)
      else $error("Transaction issued beyond the outstanding limit");

endmodule

`default_nettype wire

/* rtl/bus_error_latch.sv */
// First bus error capture FSM with the failing type and the retirement context
`timescale 1ns/1ns
`default_nettype none

module bus_error_latch (
  input  logic clk,
  input  logic rst_n,
  input  logic resp_valid_i,
  input  logic resp_err_i,
  input  logic resp_is_write_i,
  input  logic wb_valid_i,
  input  logic nmi_taken_i,
  output logic err_latched_o,
  output logic bus_error_is_write_o,
  output logic retire_at_error_o
);

  import nmi_watch_pkg::*;

  err_state_e state_q;
  err_state_e state_d;
  logic       capture;
  logic       is_write_q;
  logic       retire_q;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  // Only an error seen while idle is captured, later ones are masked
  assign capture = resp_valid_i && resp_err_i && (state_q == ERR_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ERR_IDLE: begin
        // A new error outranks a handler pulse in the same cycle
        if (capture) begin
          state_d = ERR_LATCHED;
        end
      end
      ERR_LATCHED: begin
        if (nmi_taken_i) begin
          state_d = ERR_IDLE;
        end
      end
      default: state_d = ERR_IDLE;
    endcase
  end

  // State register and the context captured with the first error
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ERR_IDLE;
      is_write_q <= 1'b0;
      retire_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        is_write_q <= resp_is_write_i;
        retire_q   <= wb_valid_i;
      end
    end
  end

  assign err_latched_o        = (state_q == ERR_LATCHED);
  assign bus_error_is_write_o = is_write_q;
  assign retire_at_error_o    = retire_q;

  // A captured error is visible the next cycle together with its type
  a_capture_latches :
    assert property (@(posedge clk) disable iff (!rst_n)
                     capture |=> (state_q == ERR_LATCHED) &&
                                 (is_write_q == $past(resp_is_write_i)))
      else $error("Captured bus error not held as latched");

endmodule

`default_nettype wire

/* rtl/nmi_retire_budget.sv */
// Qualified retirement counter and sticky overdue flag for the NMI handler
`timescale 1ns/1ns
`default_nettype none

module nmi_retire_budget (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      err_latched_i,
  input  logic                      retire_at_error_i,
  input  logic                      wb_valid_i,
  input  logic                      debug_mode_i,
  input  logic                      step_i,
  input  logic                      stepie_i,
  output nmi_watch_pkg::retire_cnt_t retire_cnt_o,
  output logic                      nmi_overdue_o
);

  import nmi_watch_pkg::*;

  retire_cnt_t cnt_q;
  retire_cnt_t budget;
  logic        retire_qual;
  logic        overdue_q;

  //////////////////////////////////////////////////////////////////////
  // Retirement qualification
  //////////////////////////////////////////////////////////////////////

  // Debug mode and masked single stepping hold off the NMI, so they do not count
  assign retire_qual = wb_valid_i && err_latched_i && !debug_mode_i &&
                       !(step_i && !stepie_i);

  // One retirement in the error cycle already used part of the allowance
  assign budget = retire_at_error_i ? RETIRE_BUDGET_AT_ERROR : RETIRE_BUDGET_NO_RETIRE;

  //////////////////////////////////////////////////////////////////////
  // Counter and overdue flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!err_latched_i) begin
      cnt_q <= '0;
    end else if (retire_qual && (cnt_q != '1)) begin
      // Saturate at three
      cnt_q <= cnt_q + retire_cnt_t'(1);
    end
  end

  // Once set the flag stays up until the next reset
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      overdue_q <= 1'b0;
    end else if (cnt_q >= budget) begin
      overdue_q <= 1'b1;
    end
  end

  assign retire_cnt_o  = cnt_q;
  assign nmi_overdue_o = overdue_q;

  // The count only lingers for the single cycle after the latch releases
  a_cnt_zero_when_idle :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (!err_latched_i && !$past(err_latched_i)) |-> (cnt_q == '0))
      else $error("Retirement count nonzero while no error is latched");

endmodule

`default_nettype wire

/* rtl/nmi_retire_monitor.sv */
// Top level of the NMI retirement watchdog joining tracker, latch and budget
`timescale 1ns/1ns
`default_nettype none

module nmi_retire_monitor #(
  parameter int MAX_OUTSTANDING = nmi_watch_pkg::MAX_OUTSTANDING_DEFAULT
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Data bus strobes, observed only
  input  logic                                 bus_req_i,
  input  logic                                 bus_gnt_i,
  input  logic                                 bus_we_i,
  input  logic                                 bus_rvalid_i,
  input  logic                                 bus_err_i,
  // Core state
  input  logic                                 wb_valid_i,
  input  logic                                 nmi_taken_i,
  input  logic                                 debug_mode_i,
  input  logic                                 step_i,
  input  logic                                 stepie_i,
  output logic [$clog2(MAX_OUTSTANDING+1)-1:0] outstanding_cnt_o,
  output logic                                 bus_error_latched_o,
  output logic                                 bus_error_is_write_o,
  output logic                                 retire_at_error_o,
  output nmi_watch_pkg::retire_cnt_t           retire_cnt_o,
  output logic                                 nmi_overdue_o
);

  logic resp_valid;
  logic resp_err;
  logic resp_is_write;

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  obi_outstanding_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) obi_outstanding_tracker_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_req_i         (bus_req_i),
    .bus_gnt_i         (bus_gnt_i),
    .bus_we_i          (bus_we_i),
    .bus_rvalid_i      (bus_rvalid_i),
    .bus_err_i         (bus_err_i),
    .resp_valid_o      (resp_valid),
    .resp_err_o        (resp_err),
    .resp_is_write_o   (resp_is_write),
    .outstanding_cnt_o (outstanding_cnt_o)
  );

  // Latched outputs appear one cycle after the error response
  bus_error_latch bus_error_latch_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .resp_valid_i         (resp_valid),
    .resp_err_i           (resp_err),
    .resp_is_write_i      (resp_is_write),
    .wb_valid_i           (wb_valid_i),
    .nmi_taken_i          (nmi_taken_i),
    .err_latched_o        (bus_error_latched_o),
    .bus_error_is_write_o (bus_error_is_write_o),
    .retire_at_error_o    (retire_at_error_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Retirement side
  //////////////////////////////////////////////////////////////////////

  nmi_retire_budget nmi_retire_budget_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .err_latched_i     (bus_error_latched_o),
    .retire_at_error_i (retire_at_error_o),
    .wb_valid_i        (wb_valid_i),
    .debug_mode_i      (debug_mode_i),
    .step_i            (step_i),
    .stepie_i          (stepie_i),
    .retire_cnt_o      (retire_cnt_o),
    .nmi_overdue_o     (nmi_overdue_o)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// Free running testbench clock source
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  // Starts low so the first rising edge lands half a period in
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* verif/nmi_retire_monitor_tb.sv */
// Testbench for the NMI retirement watchdog with stimulus, cycle model, compare and watchdog
`timescale 1ns/1ns
`default_nettype none

module nmi_retire_monitor_tb;

  localparam int CLK_PERIOD_NS  = 20;
  localparam int MAX_OUT        = 2;
  localparam int CNT_W          = $clog2(MAX_OUT + 1);
  localparam int RANDOM_CYCLES  = 400;
  // One segment holds a reset, a directed part and a random part with room to spare
  localparam int SEGMENT_CYCLES = RANDOM_CYCLES + 60;
  localparam int SEGMENTS       = 3;
  localparam int TIMEOUT_NS     = 2 * SEGMENTS * SEGMENT_CYCLES * CLK_PERIOD_NS;

  logic                       clk;
  logic                       rst_n;
  logic                       bus_req;
  logic                       bus_gnt;
  logic                       bus_we;
  logic                       bus_rvalid;
  logic                       bus_err;
  logic                       wb_valid;
  logic                       nmi_taken;
  logic                       debug_mode;
  logic                       step;
  logic                       stepie;
  logic [CNT_W-1:0]           outstanding_cnt;
  logic                       bus_error_latched;
  logic                       bus_error_is_write;
  logic                       retire_at_error;
  nmi_watch_pkg::retire_cnt_t retire_cnt;
  logic                       nmi_overdue;

  bit          checks_on;
  int          error_count;
  logic [31:0] rng_state;
  logic        mode_dbg;
  logic        mode_step;
  logic        mode_stepie;

  // Reference model state that advances once per rising edge
  bit   m_types[$];
  logic m_latched;
  logic m_is_write;
  logic m_retire_at_err;
  int   m_retire_cnt;
  logic m_overdue;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) tb_clk_gen_i (.clk_o(clk));

  nmi_retire_monitor #(.MAX_OUTSTANDING(MAX_OUT)) nmi_retire_monitor_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .bus_req_i            (bus_req),
    .bus_gnt_i            (bus_gnt),
    .bus_we_i             (bus_we),
    .bus_rvalid_i         (bus_rvalid),
    .bus_err_i            (bus_err),
    .wb_valid_i           (wb_valid),
    .nmi_taken_i          (nmi_taken),
    .debug_mode_i         (debug_mode),
    .step_i               (step),
    .stepie_i             (stepie),
    .outstanding_cnt_o    (outstanding_cnt),
    .bus_error_latched_o  (bus_error_latched),
    .bus_error_is_write_o (bus_error_is_write),
    .retire_at_error_o    (retire_at_error),
    .retire_cnt_o         (retire_cnt),
    .nmi_overdue_o        (nmi_overdue)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void model_reset();
    m_types.delete();
    m_latched       = 1'b0;
    m_is_write      = 1'b0;
    m_retire_at_err = 1'b0;
    m_retire_cnt    = 0;
    m_overdue       = 1'b0;
  endfunction

  // One clock edge of the watchdog with all decisions taken on pre-edge state
  function automatic void model_step(input logic issue, input logic we, input logic rvalid,
                                     input logic err, input logic wb, input logic nmi,
                                     input logic dbg, input logic stp, input logic stpie);
    bit oldest;
    bit capture;
    int budget;
    oldest  = (m_types.size() > 0) ? m_types[0] : 1'b0;
    capture = rvalid && err && !m_latched;
    // Two retirements allowed if one went with the error, three otherwise
    budget  = m_retire_at_err ? 2 : 3;
    if (m_retire_cnt >= budget) begin
      m_overdue = 1'b1;
    end
    if (!m_latched) begin
      m_retire_cnt = 0;
    end else if (wb && !dbg && !(stp && !stpie) && (m_retire_cnt < 3)) begin
      m_retire_cnt++;
    end
    // An error in an idle cycle outranks the handler pulse
    if (capture) begin
      m_latched       = 1'b1;
      m_is_write      = oldest;
      m_retire_at_err = wb;
    end else if (m_latched && nmi) begin
      m_latched = 1'b0;
    end
    if (rvalid && (m_types.size() > 0)) begin
      void'(m_types.pop_front());
    end
    if (issue) begin
      m_types.push_back(we);
    end
  endfunction

  // The model clears with the asynchronous reset and steps on each rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      model_step(bus_req && bus_gnt, bus_we, bus_rvalid, bus_err, wb_valid, nmi_taken,
                 debug_mode, step, stepie);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare and watchdog
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Every output is compared with the model on each falling edge
  always @(negedge clk) begin
    if (checks_on) begin
      check_value("outstanding_cnt_o", 32'(outstanding_cnt), 32'(m_types.size()));
      check_value("bus_error_latched_o", 32'(bus_error_latched), 32'(m_latched));
      check_value("bus_error_is_write_o", 32'(bus_error_is_write), 32'(m_is_write));
      check_value("retire_at_error_o", 32'(retire_at_error), 32'(m_retire_at_err));
      check_value("retire_cnt_o", 32'(retire_cnt), 32'(m_retire_cnt));
      check_value("nmi_overdue_o", 32'(nmi_overdue), 32'(m_overdue));
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Simulation did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic apply_inputs(input logic req, input logic gnt, input logic we,
                              input logic rvalid, input logic err, input logic wb,
                              input logic nmi, input logic dbg, input logic stp,
                              input logic stpie);
    bus_req    = req;
    bus_gnt    = gnt;
    bus_we     = we;
    bus_rvalid = rvalid;
    bus_err    = err;
    wb_valid   = wb;
    nmi_taken  = nmi;
    debug_mode = dbg;
    step       = stp;
    stepie     = stpie;
  endtask

  task automatic drive_cycle(input logic req, input logic gnt, input logic we,
                             input logic rvalid, input logic err, input logic wb,
                             input logic nmi, input logic dbg, input logic stp,
                             input logic stpie);
    @(posedge clk);
    #1;
    apply_inputs(req, gnt, we, rvalid, err, wb, nmi, dbg, stp, stpie);
  endtask

  task automatic issue_txn(input logic we);
    drive_cycle(1'b1, 1'b1, we, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic respond(input logic err, input logic wb);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, err, wb, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic retire(input logic dbg, input logic stp, input logic stpie);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, dbg, stp, stpie);
  endtask

  task automatic pulse_nmi(input logic rvalid, input logic err);
    drive_cycle(1'b0, 1'b0, 1'b0, rvalid, err, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    apply_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Legal random traffic whose decisions use the model count after the edge
  task automatic random_cycle();
    logic [31:0] r;
    logic        rv;
    logic        gnt;
    @(posedge clk);
    #1;
    rng_state = xorshift32(rng_state);
    r         = rng_state;
    rv        = (m_types.size() != 0) && r[0];
    gnt       = r[3];
    // Never issue past the queue depth
    if ((m_types.size() == MAX_OUT) && !rv) begin
      gnt = 1'b0;
    end
    if (r[11:8] == 4'd0) begin
      mode_dbg = !mode_dbg;
    end
    if (r[15:12] == 4'd0) begin
      mode_step   = !mode_step;
      mode_stepie = r[16];
    end
    apply_inputs(r[1] | r[2], gnt, r[4], rv, r[5] & r[6], r[7], r[21:17] == 5'd0,
                 mode_dbg, mode_step, mode_stepie);
  endtask

  initial begin
    checks_on   = 1'b0;
    error_count = 0;
    rng_state   = 32'h5175a316;
    mode_dbg    = 1'b0;
    mode_step   = 1'b0;
    mode_stepie = 1'b0;
    model_reset();
    rst_n = 1'b0;
    apply_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(posedge clk);
    checks_on = 1'b1;
    @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Read first, error with a retirement in the same cycle, budget of two
    issue_txn(1'b0);
    issue_txn(1'b1);
    respond(1'b1, 1'b1);
    issue_txn(1'b1);
    respond(1'b1, 1'b0);
    respond(1'b0, 1'b0);
    retire(1'b1, 1'b0, 1'b0);
    retire(1'b0, 1'b1, 1'b0);
    retire(1'b0, 1'b1, 1'b1);
    retire(1'b0, 1'b0, 1'b0);
    retire(1'b0, 1'b0, 1'b0);
    retire(1'b0, 1'b0, 1'b0);
    pulse_nmi(1'b0, 1'b0);
    idle_cycles(3);
    repeat (RANDOM_CYCLES) random_cycle();

    // Write first, budget of three, then release and recapture
    apply_reset();
    issue_txn(1'b1);
    issue_txn(1'b0);
    respond(1'b1, 1'b0);
    retire(1'b0, 1'b0, 1'b0);
    retire(1'b0, 1'b0, 1'b0);
    // Error while latched is dropped and the pulse releases
    pulse_nmi(1'b1, 1'b1);
    issue_txn(1'b0);
    // Error in an idle cycle wins over the pulse
    pulse_nmi(1'b1, 1'b1);
    retire(1'b0, 1'b0, 1'b0);
    retire(1'b0, 1'b0, 1'b0);
    retire(1'b0, 1'b0, 1'b0);
    idle_cycles(2);
    pulse_nmi(1'b0, 1'b0);
    idle_cycles(3);
    repeat (RANDOM_CYCLES) random_cycle();

    apply_reset();
    repeat (RANDOM_CYCLES) random_cycle();
    idle_cycles(2);

    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* nmi_retire_monitor.f */
rtl/nmi_watch_pkg.sv
rtl/obi_outstanding_tracker.sv
rtl/bus_error_latch.sv
rtl/nmi_retire_budget.sv
rtl/nmi_retire_monitor.sv
verif/tb_clk_gen.sv
verif/nmi_retire_monitor_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := nmi_retire_monitor_tb
RTL_TOP    := nmi_retire_monitor
FILELIST   := nmi_retire_monitor.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
